/* design/effect_unit.sv */
`default_nettype none
`include "intercom_settings.svh"

module effect_unit (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sample_strobe,
   input  intercom_pkg::sample_t mic_aud,
   voice_ctrl_if.datapath        ctrl,
   output intercom_pkg::sample_t tx_aud,
   output logic                  tx_valid
);
   import intercom_pkg::*;

   localparam int ECHO_AW = $clog2(`ECHO_DEPTH);
   localparam int TREM_W  = $clog2(`TREM_HALF_PERIOD + 1);

   sample_t             echo_line [`ECHO_DEPTH];
   logic [ECHO_AW-1:0]  echo_ptr;
   sample_t             echo_tap;
   logic [TREM_W-1:0]   trem_cnt;
   logic                trem_phase;                    // Low is the full-level phase
   sample_t             rev_acc;
   sample_t             rev_next;
   sample_t             soft_val;
   sample_t             fx_out;

   // Oldest entry, written ECHO_DEPTH strobes ago
   assign echo_tap = echo_line[echo_ptr];

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `ECHO_DEPTH; i++) begin
            echo_line[i] <= '0;
         end
         echo_ptr <= '0;
      end else if (sample_strobe) begin
         echo_line[echo_ptr] <= mic_aud;
         if (echo_ptr == ECHO_AW'(`ECHO_DEPTH - 1)) begin
            echo_ptr <= '0;
         end else begin
            echo_ptr <= echo_ptr + 1'b1;
         end
      end
   end

   // Tremolo phase flips every TREM_HALF_PERIOD strobes
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         trem_cnt   <= '0;
         trem_phase <= 1'b0;
      end else if (sample_strobe) begin
         if (trem_cnt == TREM_W'(`TREM_HALF_PERIOD - 1)) begin
            trem_cnt   <= '0;
            trem_phase <= !trem_phase;
         end else begin
            trem_cnt <= trem_cnt + 1'b1;
         end
      end
   end

   // One-pole smoothing, new = mic/2 + acc/2
   assign rev_next = (mic_aud >> 1) + (rev_acc >> 1);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         rev_acc <= '0;
      end else if (sample_strobe) begin
         rev_acc <= rev_next;
      end
   end

   // Compress by four above the knee
   always_comb begin
      if (mic_aud > 8'(`SOFT_KNEE)) begin
         soft_val = 8'(`SOFT_KNEE) + ((mic_aud - 8'(`SOFT_KNEE)) >> 2);
      end else begin
         soft_val = mic_aud;
      end
   end

   always_comb begin
      fx_out = mic_aud;
      if (ctrl.fx_enable) begin
         case (ctrl.effect)
            ECHO:    fx_out = (mic_aud >> 1) + (echo_tap >> 1);
            TREMOLO: fx_out = trem_phase ? (mic_aud >> 1) : mic_aud;
            REVERB:  fx_out = rev_next;
            SOFT:    fx_out = soft_val;
            default: fx_out = mic_aud;                  // NORMAL and unused codes
         endcase
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= sample_strobe && ctrl.talk;
      end
   end

   // Holds until the next transmitted sample
   always_ff @(posedge clk) begin
      if (sample_strobe && ctrl.talk) begin
         tx_aud <= fx_out;
      end
   end

endmodule

`default_nettype wire

/* design/intercom_pkg.sv */
`default_nettype none

package intercom_pkg;

   // One unsigned audio sample from the codec
   typedef logic [7:0] sample_t;

   // Half-duplex channel direction
   typedef enum logic [1:0] {
      LISTEN = 2'd0,
      TALK   = 2'd1
   } talk_state_t;

   // Effect ring, codes 5 to 7 are unused
   typedef enum logic [2:0] {
      NORMAL  = 3'd0,
      ECHO    = 3'd1,
      TREMOLO = 3'd2,
      REVERB  = 3'd3,
      SOFT    = 3'd4
   } effect_t;

endpackage

`default_nettype wire

/* design/intercom_settings.svh */
`ifndef INTERCOM_SETTINGS_SVH
`define INTERCOM_SETTINGS_SVH

// Mic level at or above this opens the noise gate
`define GATE_THRESHOLD 64

// Echo delay in sample strobes
`define ECHO_DEPTH 16

// Strobes per tremolo phase
`define TREM_HALF_PERIOD 8

// Soft clipper compresses by four above this level
`define SOFT_KNEE 128

// Right shift after the speaker volume multiply
`define VOL_SHIFT 3

`endif

/* design/intercom_top.sv */
`default_nettype none

module intercom_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        sample_strobe,  // One-cycle codec strobe
   input  intercom_pkg::sample_t       mic_aud,
   input  intercom_pkg::sample_t       spk_aud,
   input  logic                        ng_en,
   input  logic                        ptt_en,
   input  logic                        fx_button,
   input  logic                        fx_on,
   input  logic                        mute,
   input  logic [2:0]                  volume,
   output intercom_pkg::sample_t       tx_aud,
   output logic                        tx_valid,
   output intercom_pkg::sample_t       spk_out,
   output logic                        spk_out_valid,
   output intercom_pkg::talk_state_t   state,
   output intercom_pkg::effect_t       current_effect
);

   voice_ctrl_if ctrl_if ();                           // Control decisions to both datapaths

   voice_control u_control (
      .clk            (clk),
      .rst            (rst),
      .sample_strobe  (sample_strobe),
      .mic_aud        (mic_aud),
      .spk_aud        (spk_aud),
      .ng_en          (ng_en),
      .ptt_en         (ptt_en),
      .fx_button      (fx_button),
      .fx_on          (fx_on),
      .mute           (mute),
      .state          (state),
      .current_effect (current_effect),
      .ctrl           (ctrl_if.control)
   );

   effect_unit u_effect (
      .clk           (clk),
      .rst           (rst),
      .sample_strobe (sample_strobe),
      .mic_aud       (mic_aud),
      .ctrl          (ctrl_if.datapath),
      .tx_aud        (tx_aud),
      .tx_valid      (tx_valid)
   );

   speaker_path u_speaker (
      .clk           (clk),
      .rst           (rst),
      .sample_strobe (sample_strobe),
      .spk_aud       (spk_aud),
      .volume        (volume),
      .ctrl          (ctrl_if.datapath),
      .spk_out       (spk_out),
      .spk_out_valid (spk_out_valid)
   );

endmodule

`default_nettype wire

/* design/speaker_path.sv */
`default_nettype none
`include "intercom_settings.svh"

module speaker_path (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sample_strobe,
   input  intercom_pkg::sample_t spk_aud,
   input  logic [2:0]            volume,
   voice_ctrl_if.datapath        ctrl,
   output intercom_pkg::sample_t spk_out,
   output logic                  spk_out_valid
);
   import intercom_pkg::*;

   logic [10:0] vol_prod;                              // 8-bit sample times 3-bit volume
   sample_t     vol_scaled;
   sample_t     spk_next;

   assign vol_prod   = spk_aud * volume;
   assign vol_scaled = 8'(vol_prod >> `VOL_SHIFT);

   // Silent while talking or muted
   assign spk_next = ctrl.listen_en ? vol_scaled : '0;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         spk_out_valid <= 1'b0;
      end else begin
         spk_out_valid <= sample_strobe;
      end
   end

   always_ff @(posedge clk) begin
      if (sample_strobe) begin
         spk_out <= spk_next;
      end
   end

endmodule

`default_nettype wire

/* design/voice_control.sv */
`default_nettype none
`include "intercom_settings.svh"

module voice_control (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        sample_strobe,
   input  intercom_pkg::sample_t       mic_aud,
   input  intercom_pkg::sample_t       spk_aud,
   input  logic                        ng_en,          // Noise gate enable
   input  logic                        ptt_en,         // Push-to-talk
   input  logic                        fx_button,      // Asynchronous effect cycle button
   input  logic                        fx_on,          // Effect on/off switch
   input  logic                        mute,
   output intercom_pkg::talk_state_t   state,
   output intercom_pkg::effect_t       current_effect,
   voice_ctrl_if.control               ctrl
);
   import intercom_pkg::*;

   talk_state_t state_q, state_next;
   effect_t     eff_q, eff_next;
   logic        gate_open;
   logic        spk_active;
   logic        btn_sync1, btn_sync2, btn_sync2_d;
   logic        btn_rise;

   assign gate_open  = (mic_aud >= 8'(`GATE_THRESHOLD));
   assign spk_active = (spk_aud != '0);                 // Incoming audio has priority

   // Talk/listen decision, only taken on a sample strobe
   always_comb begin
      state_next = state_q;
      case (state_q)
         LISTEN: begin
            if (!spk_active && (ptt_en || (ng_en && gate_open))) begin
               state_next = TALK;
            end
         end
         TALK: begin
            if (spk_active || (!ptt_en && !ng_en) || (ng_en && !ptt_en && !gate_open)) begin
               state_next = LISTEN;
            end
         end
         default: state_next = LISTEN;
      endcase
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state_q <= LISTEN;
      end else if (sample_strobe) begin
         state_q <= state_next;
      end
   end

   // Two-flop synchronizer plus one stage for edge detect
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         btn_sync1   <= 1'b0;
         btn_sync2   <= 1'b0;
         btn_sync2_d <= 1'b0;
      end else begin
         btn_sync1   <= fx_button;
         btn_sync2   <= btn_sync1;
         btn_sync2_d <= btn_sync2;
      end
   end

   assign btn_rise = btn_sync2 && !btn_sync2_d;

   // Effect ring advances once per press
   always_comb begin
      eff_next = eff_q;
      case (eff_q)
         NORMAL:  if (btn_rise) eff_next = ECHO;
         ECHO:    if (btn_rise) eff_next = TREMOLO;
         TREMOLO: if (btn_rise) eff_next = REVERB;
         REVERB:  if (btn_rise) eff_next = SOFT;
         SOFT:    if (btn_rise) eff_next = NORMAL;
         default: eff_next = NORMAL;                    // Recover from unused codes
      endcase
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         eff_q <= NORMAL;
      end else begin
         eff_q <= eff_next;
      end
   end

   assign state          = state_q;
   assign current_effect = eff_q;

   // Decoded enables for the datapath
   assign ctrl.talk      = (state_q == TALK);
   assign ctrl.fx_enable = (state_q == TALK) && fx_on;
   assign ctrl.effect    = eff_q;
   assign ctrl.listen_en = (state_q == LISTEN) && !mute;

endmodule

`default_nettype wire

/* design/voice_ctrl_if.sv */
`default_nettype none

interface voice_ctrl_if;
   import intercom_pkg::*;

   logic    talk;       // Channel is transmitting
   logic    fx_enable;  // Effect applied to transmit audio
   effect_t effect;     // Selected effect
   logic    listen_en;  // Speaker audio passes to output

   modport control (
      output talk,
      output fx_enable,
      output effect,
      output listen_en
   );

   modport datapath (
      input talk,
      input fx_enable,
      input effect,
      input listen_en
   );

endinterface

`default_nettype wire

/* intercom.f */
+incdir+design
+incdir+sim
design/intercom_pkg.sv
design/voice_ctrl_if.sv
design/voice_control.sv
design/effect_unit.sv
design/speaker_path.sv
design/intercom_top.sv
sim/tb_intercom.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log
{ verilator --binary --timing -Wno-fatal -f intercom.f --top-module tb_intercom \
     -o tb_intercom && ./obj_dir/tb_intercom; } > "$LOG" 2>&1 ||
   echo "tests failed" >> "$LOG"
cat "$LOG"
grep -q "tests failed" "$LOG" && { echo "Simulation FAILED, see $LOG"; exit 1; }
echo "Simulation PASSED"
exit 0

/* sim/intercom_model.svh */
`ifndef INTERCOM_MODEL_SVH
`define INTERCOM_MODEL_SVH

// Reference state, advanced once per clock from the inputs seen before the edge
talk_state_t m_state;
effect_t     m_effect;
logic        m_btn_sync1;
logic        m_btn_sync2;
logic        m_btn_prev;
sample_t     m_echo_hist [`ECHO_DEPTH];       // Index 0 is the previous strobe's sample
sample_t     m_reverb;
int          m_strobe_cnt;                    // Strobes since reset, drives tremolo phase
sample_t     m_tx_aud;
logic        m_tx_valid;
sample_t     m_spk_out;
logic        m_spk_valid;

function automatic talk_state_t next_talk_state(input talk_state_t cur, input sample_t mic,
                                                input sample_t spk, input logic ptt,
                                                input logic ng);
   logic loud;
   loud = (int'(mic) >= `GATE_THRESHOLD);
   if (cur == LISTEN) begin
      if (spk == 0 && (ptt || (ng && loud))) return TALK;
      return LISTEN;
   end
   if (spk != 0) return LISTEN;                // Incoming audio always wins
   if (!ptt && !ng) return LISTEN;
   if (ng && !ptt && !loud) return LISTEN;
   return TALK;
endfunction

function automatic effect_t next_effect(input effect_t cur);
   case (cur)
      NORMAL:  return ECHO;
      ECHO:    return TREMOLO;
      TREMOLO: return REVERB;
      REVERB:  return SOFT;
      default: return NORMAL;
   endcase
endfunction

task automatic model_reset();
   m_state      = LISTEN;
   m_effect     = NORMAL;
   m_btn_sync1  = 1'b0;
   m_btn_sync2  = 1'b0;
   m_btn_prev   = 1'b0;
   m_reverb     = '0;
   m_strobe_cnt = 0;
   m_tx_valid   = 1'b0;
   m_spk_valid  = 1'b0;
   m_spk_out    = '0;
   for (int i = 0; i < `ECHO_DEPTH; i++) begin
      m_echo_hist[i] = '0;
   end
endtask

task automatic model_step(input logic strobe, input sample_t mic, input sample_t spk,
                          input logic ptt, input logic ng, input logic btn, input logic fx,
                          input logic mute_sw, input logic [2:0] vol);
   sample_t delayed;
   sample_t acc_new;
   sample_t shaped;
   logic    rise;
   rise        = m_btn_sync2 && !m_btn_prev;   // Edge seen on the second flop
   m_tx_valid  = 1'b0;
   m_spk_valid = 1'b0;
   if (strobe) begin
      delayed = m_echo_hist[`ECHO_DEPTH-1];
      acc_new = sample_t'(int'(mic) / 2 + int'(m_reverb) / 2);
      shaped  = mic;
      if (m_state == TALK && fx) begin
         case (m_effect)
            ECHO:    shaped = sample_t'(int'(mic) / 2 + int'(delayed) / 2);
            TREMOLO: if ((m_strobe_cnt / `TREM_HALF_PERIOD) % 2 == 1) shaped = mic / 2;
            REVERB:  shaped = acc_new;
            SOFT:    if (int'(mic) > `SOFT_KNEE)
                        shaped = sample_t'(`SOFT_KNEE + (int'(mic) - `SOFT_KNEE) / 4);
            default: shaped = mic;
         endcase
      end
      if (m_state == TALK) begin
         m_tx_valid = 1'b1;
         m_tx_aud   = shaped;
      end
      m_spk_valid = 1'b1;
      m_spk_out   = (m_state == LISTEN && !mute_sw) ?
                    sample_t'((int'(spk) * int'(vol)) >> `VOL_SHIFT) : 8'd0;
      for (int i = `ECHO_DEPTH - 1; i > 0; i--) begin
         m_echo_hist[i] = m_echo_hist[i-1];
      end
      m_echo_hist[0] = mic;
      m_reverb       = acc_new;
      m_strobe_cnt++;
      m_state = next_talk_state(m_state, mic, spk, ptt, ng);
   end
   if (rise) m_effect = next_effect(m_effect);
   m_btn_prev  = m_btn_sync2;
   m_btn_sync2 = m_btn_sync1;
   m_btn_sync1 = btn;
endtask

`endif

/* sim/tb_intercom.sv */
`default_nettype none
`include "intercom_settings.svh"

module tb_intercom;
   import intercom_pkg::*;

   localparam int VALID_TIMEOUT = 8;           // Cycles allowed for a valid pulse

   logic        clk;
   logic        rst;
   logic        sample_strobe;
   sample_t     mic_aud;
   sample_t     spk_aud;
   logic        ng_en;
   logic        ptt_en;
   logic        fx_button;
   logic        fx_on;
   logic        mute;
   logic [2:0]  volume;
   sample_t     tx_aud;
   logic        tx_valid;
   sample_t     spk_out;
   logic        spk_out_valid;
   talk_state_t state;
   effect_t     current_effect;

   logic [31:0] rng_state = 32'hda6933e0;
   string       test_name = "reset";
   effect_t     ring [5] = '{NORMAL, ECHO, TREMOLO, REVERB, SOFT};

   `include "intercom_model.svh"

   intercom_top UUT (
      .clk            (clk),
      .rst            (rst),
      .sample_strobe  (sample_strobe),
      .mic_aud        (mic_aud),
      .spk_aud        (spk_aud),
      .ng_en          (ng_en),
      .ptt_en         (ptt_en),
      .fx_button      (fx_button),
      .fx_on          (fx_on),
      .mute           (mute),
      .volume         (volume),
      .tx_aud         (tx_aud),
      .tx_valid       (tx_valid),
      .spk_out        (spk_out),
      .spk_out_valid  (spk_out_valid),
      .state          (state),
      .current_effect (current_effect)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic sample_t rand_sample();
      return sample_t'(next_random() >> 8);
   endfunction

   task automatic halt_on_failure();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic report_failure(input string msg);
      $display("%s in test %s", msg, test_name);
      halt_on_failure();
   endtask

   task automatic check_state(input string name, input talk_state_t expected,
                              input talk_state_t actual);
      if (actual !== expected) begin
         $display("Error: %s expected %0d actual %0d", name, expected, actual);
         halt_on_failure();
      end
   endtask

   task automatic check_effect(input string name, input effect_t expected,
                               input effect_t actual);
      if (actual !== expected) begin
         $display("Error: %s expected %0d actual %0d", name, expected, actual);
         halt_on_failure();
      end
   endtask

   task automatic check_sample(input string name, input sample_t expected,
                               input sample_t actual);
      if (actual !== expected) begin
         $display("Error: %s expected %0d actual %0d", name, expected, actual);
         halt_on_failure();
      end
   endtask

   // Outputs are stable at the falling edge, then the model advances
   always @(negedge clk) begin
      if (rst !== 1'b0) begin
         model_reset();
      end else begin
         check_state({test_name, ": state"}, m_state, state);
         check_effect({test_name, ": current_effect"}, m_effect, current_effect);
         if (tx_valid !== m_tx_valid) begin
            report_failure(m_tx_valid ? "tx_valid pulse missing" : "unexpected tx_valid pulse");
         end else if (tx_valid) begin
            check_sample({test_name, ": tx_aud"}, m_tx_aud, tx_aud);
         end
         if (spk_out_valid !== m_spk_valid) begin
            report_failure(m_spk_valid ? "spk_out_valid pulse missing" :
                           "unexpected spk_out_valid pulse");
         end else if (spk_out_valid) begin
            check_sample({test_name, ": spk_out"}, m_spk_out, spk_out);
         end
         model_step(sample_strobe, mic_aud, spk_aud, ptt_en, ng_en, fx_button, fx_on,
                    mute, volume);
      end
   end

   task automatic tick();
      @(posedge clk);
      #10;                                      // Inputs change just after the edge
   endtask

   task automatic wait_spk_valid();
      int cycles;
      cycles = 0;
      while (!spk_out_valid && cycles < VALID_TIMEOUT) begin
         tick();
         cycles++;
      end
      if (!spk_out_valid) report_failure("spk_out_valid never arrived");
   endtask

   task automatic wait_tx_valid();
      int cycles;
      cycles = 0;
      while (!tx_valid && cycles < VALID_TIMEOUT) begin
         tick();
         cycles++;
      end
      if (!tx_valid) report_failure("tx_valid never arrived");
   endtask

   // One strobe, then a random gap of at least two idle cycles
   task automatic send_sample(input sample_t mic, input sample_t spk);
      logic expect_tx;
      int   gap;
      sample_strobe = 1'b1;
      mic_aud       = mic;
      spk_aud       = spk;
      expect_tx     = (m_state == TALK);
      tick();
      sample_strobe = 1'b0;
      wait_spk_valid();
      if (expect_tx) wait_tx_valid();
      gap = 2 + int'(next_random() % 3);
      repeat (gap) tick();
   endtask

   task automatic press_button(input int hold);
      fx_button = 1'b1;
      repeat (hold) tick();
      fx_button = 1'b0;
      repeat (4) tick();
   endtask

   initial begin
      int      k;
      int      n;
      sample_t mic;
      sample_t spk;
      rst = 1'b1;
      sample_strobe = 1'b0;
      mic_aud = '0;
      spk_aud = '0;
      ng_en = 1'b0;
      ptt_en = 1'b0;
      fx_button = 1'b0;
      fx_on = 1'b0;
      mute = 1'b0;
      volume = 3'd4;
      repeat (4) tick();
      rst = 1'b0;

      test_name = "reset_ptt";
      check_state(test_name, LISTEN, state);
      check_effect(test_name, NORMAL, current_effect);
      ptt_en = 1'b1;
      send_sample(rand_sample(), 8'd0);
      check_state(test_name, TALK, state);
      send_sample(rand_sample(), 8'd0);
      send_sample(rand_sample(), 8'd0);
      ptt_en = 1'b0;
      send_sample(rand_sample(), 8'd0);
      check_state(test_name, LISTEN, state);

      test_name = "noise_gate";
      ng_en = 1'b1;
      for (n = 0; n < 40; n++) begin
         send_sample(sample_t'(40 + int'(next_random() % 48)), 8'd0);
      end
      ng_en = 1'b0;
      send_sample(rand_sample(), 8'd0);

      test_name = "speaker_priority";
      ptt_en = 1'b1;
      send_sample(rand_sample(), 8'd0);
      check_state(test_name, TALK, state);
      for (n = 0; n < 6; n++) begin
         send_sample(rand_sample(), rand_sample() | 8'd1);
         check_state(test_name, LISTEN, state);
      end
      ptt_en = 1'b0;

      test_name = "effect_ring";
      for (k = 0; k < 5; k++) begin
         press_button((k == 2) ? 12 : 3 + int'(next_random() % 3));
         check_effect(test_name, ring[(k + 1) % 5], current_effect);
      end

      test_name = "transmit_fx";
      ptt_en = 1'b1;
      fx_on  = 1'b1;
      for (k = 0; k < 5; k++) begin
         check_effect(test_name, ring[k], current_effect);
         for (n = 0; n < 40; n++) begin
            send_sample(rand_sample(), 8'd0);
         end
         press_button(3);
      end

      test_name = "transmit_raw";
      fx_on = 1'b0;
      press_button(3);                          // ECHO selected but bypassed
      for (n = 0; n < 20; n++) begin
         mic = rand_sample();
         send_sample(mic, 8'd0);
         check_sample(test_name, mic, tx_aud);
      end

      test_name = "speaker_volume";
      ptt_en = 1'b0;
      send_sample(rand_sample(), 8'd0);         // Back to LISTEN
      for (n = 0; n < 30; n++) begin
         spk    = rand_sample();
         volume = 3'(next_random());
         mute   = (next_random() % 4) == 0;
         send_sample(rand_sample(), spk);
         check_sample(test_name,
                      mute ? 8'd0 : sample_t'((int'(spk) * int'(volume)) >> `VOL_SHIFT),
                      spk_out);
      end

      test_name = "speaker_talk";
      mute   = 1'b0;
      volume = 3'd7;
      ptt_en = 1'b1;
      for (n = 0; n < 8; n++) begin
         send_sample(rand_sample(), 8'd0);      // Enter TALK
         spk = rand_sample() | 8'd8;            // Loud enough to be non-zero at full volume
         send_sample(rand_sample(), spk);
         check_sample(test_name, 8'd0, spk_out);   // Talking during the strobe
         check_state(test_name, LISTEN, state);
      end

      test_name = "done";
      repeat (4) tick();
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire
